// ==== source/cp0_bus_arbiter.sv ====
`timescale 1ns/1ps

module cp0_bus_arbiter (
	input  logic                       core_req_i,
	input  logic                       core_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0] core_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0] core_wdata_i,
	output logic                       core_gnt_o,
	output logic [cp0_pkg::DATA_W-1:0] core_rdata_o,
	input  logic                       dbg_req_i,
	input  logic                       dbg_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0] dbg_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0] dbg_wdata_i,
	output logic                       dbg_gnt_o,
	output logic [cp0_pkg::DATA_W-1:0] dbg_rdata_o,
	output logic                       bus_valid_o,
	output logic                       bus_we_o,
	output logic [cp0_pkg::ADDR_W-1:0] bus_addr_o,
	output logic [cp0_pkg::DATA_W-1:0] bus_wdata_o,
	input  logic [cp0_pkg::DATA_W-1:0] regs_rdata_i,
	input  logic [cp0_pkg::DATA_W-1:0] timer_rdata_i
);
	import cp0_pkg::*;

	logic [DATA_W-1:0] rd_word; // word from the addressed peer

	// core has fixed priority, debug waits
	assign core_gnt_o = core_req_i;
	assign dbg_gnt_o  = dbg_req_i && !core_req_i;

	assign bus_valid_o = core_gnt_o || dbg_gnt_o;
	assign bus_we_o    = core_gnt_o ? core_we_i    : dbg_we_i;
	assign bus_addr_o  = core_gnt_o ? core_addr_i  : dbg_addr_i;
	assign bus_wdata_o = core_gnt_o ? core_wdata_i : dbg_wdata_i;

	// address range select
	always_comb begin
		case (bus_addr_o)
			ADDR_COUNT, ADDR_COMPARE:                   rd_word = timer_rdata_i;
			ADDR_STATUS, ADDR_CAUSE, ADDR_EPC, ADDR_PRID: rd_word = regs_rdata_i;
			default:                                    rd_word = '0; // unmapped
		endcase
	end

	assign core_rdata_o = core_gnt_o ? rd_word : '0;
	assign dbg_rdata_o  = dbg_gnt_o  ? rd_word : '0;

	a_one_grant: assert #0 (!(core_gnt_o && dbg_gnt_o))
		else $error("core and debug granted together");

endmodule

// ==== source/cp0_pkg.sv ====
package cp0_pkg;

	// bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 5;
	localparam int EXC_W  = 5;

	// register numbers on the access bus
	localparam logic [ADDR_W-1:0] ADDR_COUNT   = 5'd9;
	localparam logic [ADDR_W-1:0] ADDR_COMPARE = 5'd11;
	localparam logic [ADDR_W-1:0] ADDR_STATUS  = 5'd12;
	localparam logic [ADDR_W-1:0] ADDR_CAUSE   = 5'd13;
	localparam logic [ADDR_W-1:0] ADDR_EPC     = 5'd14;
	localparam logic [ADDR_W-1:0] ADDR_PRID    = 5'd15;

	localparam logic [DATA_W-1:0] CP0_PRID = 32'h0001_8000; // company/impl/rev

	// exception codes, anything but EXC_NONE is taken as given
	localparam logic [EXC_W-1:0] EXC_NONE = 5'h1f;
	localparam logic [EXC_W-1:0] EXC_INT  = 5'h00; // stored for an interrupt

	localparam int IRQ_LINES      = 6;
	localparam int TIMER_IRQ_LINE = 5; // count/compare shares hw line 5

	// reset values
	localparam logic [DATA_W-1:0] RST_STATUS  = '0;
	localparam logic [DATA_W-1:0] RST_CAUSE   = '0;
	localparam logic [DATA_W-1:0] RST_EPC     = '0;
	localparam logic [DATA_W-1:0] RST_COUNT   = '0;
	localparam logic [DATA_W-1:0] RST_COMPARE = '1;

	// one register word seen as status or as cause
	// reserved fields are never written and stay zero
	typedef union packed {
		struct packed {
			logic [15:0]          rsv_hi;  // 31:16
			logic [IRQ_LINES-1:0] im;      // 15:10 interrupt mask
			logic [7:0]           rsv_mid; // 9:2
			logic                 exl;     // exception level
			logic                 ie;      // global interrupt enable
		} status;
		struct packed {
			logic                 bd;      // branch delay slot
			logic [14:0]          rsv_hi;  // 30:16
			logic [IRQ_LINES-1:0] ip;      // 15:10 pending hw lines
			logic [2:0]           rsv_mid; // 9:7
			logic [EXC_W-1:0]     exc;     // 6:2 exception code
			logic [1:0]           rsv_lo;
		} cause;
	} cp0_word_u;

endpackage

// ==== source/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          bus_valid_i,
	input  logic                          bus_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0]    bus_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0]    bus_wdata_i,
	output logic [cp0_pkg::DATA_W-1:0]    rdata_o,
	input  logic [cp0_pkg::IRQ_LINES-1:0] hwirq_i,
	input  logic                          timer_irq_i,
	input  logic [cp0_pkg::EXC_W-1:0]     exc_code_i,
	input  logic                          in_bds_i,
	input  logic [cp0_pkg::DATA_W-1:0]    curr_pc_i,
	input  logic                          exit_isr_i,
	output logic                          take_exc_o,
	output logic [cp0_pkg::DATA_W-1:0]    epc_o
);
	import cp0_pkg::*;

	cp0_word_u status_q;
	cp0_word_u cause_q;
	logic [DATA_W-1:0] epc_q;

	cp0_word_u wdata_u; // bus word seen through both views
	logic [IRQ_LINES-1:0] irq_merged;

	logic have_irq;
	logic have_exc;
	logic wr_status;
	logic wr_cause;
	logic wr_epc;
	logic cause_upd; // cause write that is not overridden by a take

	assign wdata_u = bus_wdata_i;

	// timer pending joins the external lines
	always_comb begin
		irq_merged = hwirq_i;
		irq_merged[TIMER_IRQ_LINE] = hwirq_i[TIMER_IRQ_LINE] | timer_irq_i;
	end

	assign have_irq = (|(irq_merged & status_q.status.im)) && status_q.status.ie &&
		!status_q.status.exl;
	assign have_exc = (exc_code_i != EXC_NONE) && !status_q.status.exl;
	assign take_exc_o = have_irq || have_exc;

	// write decode
	assign wr_status = bus_valid_i && bus_we_i && (bus_addr_i == ADDR_STATUS);
	assign wr_cause  = bus_valid_i && bus_we_i && (bus_addr_i == ADDR_CAUSE);
	assign wr_epc    = bus_valid_i && bus_we_i && (bus_addr_i == ADDR_EPC);
	assign cause_upd = wr_cause && !take_exc_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			status_q <= RST_STATUS;
			cause_q  <= RST_CAUSE;
			epc_q    <= RST_EPC;
		end else begin
			if (take_exc_o) begin
				status_q.status.exl <= 1'b1;
				cause_q.cause.bd    <= in_bds_i;
				cause_q.cause.exc   <= have_irq ? EXC_INT : exc_code_i; // irq wins
				// in a delay slot the branch itself is re-executed
				epc_q <= in_bds_i ? (curr_pc_i - DATA_W'(4)) : curr_pc_i;
			end else if (wr_status) begin
				status_q.status.im  <= wdata_u.status.im;
				status_q.status.exl <= wdata_u.status.exl;
				status_q.status.ie  <= wdata_u.status.ie;
			end else if (wr_cause) begin
				cause_q.cause.bd  <= wdata_u.cause.bd;
				cause_q.cause.ip  <= wdata_u.cause.ip;
				cause_q.cause.exc <= wdata_u.cause.exc;
			end else if (wr_epc) begin
				epc_q <= bus_wdata_i;
			end else if (exit_isr_i) begin
				status_q.status.exl <= 1'b0; // return from handler
			end

			// pending lines track the inputs unless software writes them
			if (!cause_upd) begin
				cause_q.cause.ip <= irq_merged;
			end
		end
	end

	// read port
	always_comb begin
		case (bus_addr_i)
			ADDR_STATUS: rdata_o = status_q;
			ADDR_CAUSE:  rdata_o = cause_q;
			ADDR_EPC:    rdata_o = epc_q;
			ADDR_PRID:   rdata_o = CP0_PRID;
			default:     rdata_o = '0;
		endcase
	end

	assign epc_o = epc_q;

	a_exl_after_take: assert property (@(posedge clk) disable iff (!rst_n_i)
		take_exc_o |=> status_q.status.exl)
		else $error("EXL not set after take");

	a_no_take_in_exl: assert property (@(posedge clk) disable iff (!rst_n_i)
		status_q.status.exl |-> !take_exc_o)
		else $error("take raised with EXL set");

endmodule

// ==== source/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       bus_valid_i,
	input  logic                       bus_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0] bus_wdata_i,
	output logic [cp0_pkg::DATA_W-1:0] rdata_o,
	output logic                       timer_irq_o
);
	import cp0_pkg::*;

	logic [DATA_W-1:0] count_q;
	logic [DATA_W-1:0] compare_q;
	logic pending_q;

	logic wr_count;
	logic wr_compare;

	assign wr_count   = bus_valid_i && bus_we_i && (bus_addr_i == ADDR_COUNT);
	assign wr_compare = bus_valid_i && bus_we_i && (bus_addr_i == ADDR_COMPARE);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q   <= RST_COUNT;
			compare_q <= RST_COMPARE;
			pending_q <= 1'b0;
		end else begin
			count_q <= wr_count ? bus_wdata_i : count_q + 1'b1; // free running

			if (wr_compare) begin
				compare_q <= bus_wdata_i;
				pending_q <= 1'b0; // writing compare acknowledges the irq
			end else if (count_q == compare_q) begin
				pending_q <= 1'b1;
			end
		end
	end

	always_comb begin
		case (bus_addr_i)
			ADDR_COUNT:   rdata_o = count_q;
			ADDR_COMPARE: rdata_o = compare_q;
			default:      rdata_o = '0;
		endcase
	end

	assign timer_irq_o = pending_q;

	a_pending_clr: assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_compare |=> !pending_q)
		else $error("timer pending still set after compare write");

endmodule

// ==== source/exc_subsys_top.sv ====
`timescale 1ns/1ps

module exc_subsys_top (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          core_req_i,
	input  logic                          core_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0]    core_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0]    core_wdata_i,
	output logic                          core_gnt_o,
	output logic [cp0_pkg::DATA_W-1:0]    core_rdata_o,
	input  logic                          dbg_req_i,
	input  logic                          dbg_we_i,
	input  logic [cp0_pkg::ADDR_W-1:0]    dbg_addr_i,
	input  logic [cp0_pkg::DATA_W-1:0]    dbg_wdata_i,
	output logic                          dbg_gnt_o,
	output logic [cp0_pkg::DATA_W-1:0]    dbg_rdata_o,
	input  logic [cp0_pkg::IRQ_LINES-1:0] ext_hwirq_i,
	input  logic [cp0_pkg::EXC_W-1:0]     exc_code_i,
	input  logic                          in_bds_i,
	input  logic [cp0_pkg::DATA_W-1:0]    curr_pc_i,
	input  logic                          exit_isr_i,
	output logic                          take_exc_o,
	output logic [cp0_pkg::DATA_W-1:0]    epc_o
);
	import cp0_pkg::*;

	// shared register access bus
	logic bus_valid;
	logic bus_we;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata;

	logic [DATA_W-1:0] regs_rdata;
	logic [DATA_W-1:0] timer_rdata;
	logic timer_irq;

	cp0_bus_arbiter arbiter_inst (
		.core_req_i    (core_req_i),
		.core_we_i     (core_we_i),
		.core_addr_i   (core_addr_i),
		.core_wdata_i  (core_wdata_i),
		.core_gnt_o    (core_gnt_o),
		.core_rdata_o  (core_rdata_o),
		.dbg_req_i     (dbg_req_i),
		.dbg_we_i      (dbg_we_i),
		.dbg_addr_i    (dbg_addr_i),
		.dbg_wdata_i   (dbg_wdata_i),
		.dbg_gnt_o     (dbg_gnt_o),
		.dbg_rdata_o   (dbg_rdata_o),
		.bus_valid_o   (bus_valid),
		.bus_we_o      (bus_we),
		.bus_addr_o    (bus_addr),
		.bus_wdata_o   (bus_wdata),
		.regs_rdata_i  (regs_rdata),
		.timer_rdata_i (timer_rdata)
	);

	cp0_regs regs_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_valid_i (bus_valid),
		.bus_we_i    (bus_we),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.rdata_o     (regs_rdata),
		.hwirq_i     (ext_hwirq_i),
		.timer_irq_i (timer_irq),
		.exc_code_i  (exc_code_i),
		.in_bds_i    (in_bds_i),
		.curr_pc_i   (curr_pc_i),
		.exit_isr_i  (exit_isr_i),
		.take_exc_o  (take_exc_o),
		.epc_o       (epc_o)
	);

	cp0_timer timer_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_valid_i (bus_valid),
		.bus_we_i    (bus_we),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.rdata_o     (timer_rdata),
		.timer_irq_o (timer_irq) // lands on hw line 5
	);

endmodule

// ==== src.f ====
source/cp0_pkg.sv
source/cp0_bus_arbiter.sv
source/cp0_regs.sv
source/cp0_timer.sv
source/exc_subsys_top.sv
verification/tb_clk_gen.sv
verification/tb_exc_subsys.sv

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int HALF_PERIOD = 5; // 10 ns clock
	localparam int RST_CYCLES  = 16;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1; // released just after the edge like other inputs
	end

endmodule

// ==== verification/tb_exc_subsys.sv ====
`timescale 1ns/1ps

module tb_exc_subsys;
	import cp0_pkg::*;

	localparam int TIMEOUT_CYCLES = 64;
	localparam logic [IRQ_LINES-1:0] HW_PAT = 6'b010110; // line 5 left out
	localparam logic [DATA_W-1:0] TMR_CMP = 32'h0000_0400;
	localparam logic [DATA_W-1:0] DBG_EPC = 32'hcafe_0004;

	// one cycle of bus access and event inputs with the expected response
	typedef struct packed {
		logic req;
		logic dbg; // access goes through the debug port
		logic we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [IRQ_LINES-1:0] hwirq;
		logic [EXC_W-1:0] exc;
		logic bds;
		logic [DATA_W-1:0] pc;
		logic exit_isr;
		logic chk_rd;
		logic [DATA_W-1:0] exp_rd;
		logic exp_take;
		logic [DATA_W-1:0] exp_epc;
	} row_t;

	logic clk;
	logic rst_n;
	logic core_req_i, core_we_i, core_gnt_o;
	logic [ADDR_W-1:0] core_addr_i;
	logic [DATA_W-1:0] core_wdata_i, core_rdata_o;
	logic dbg_req_i, dbg_we_i, dbg_gnt_o;
	logic [ADDR_W-1:0] dbg_addr_i;
	logic [DATA_W-1:0] dbg_wdata_i, dbg_rdata_o;
	logic [IRQ_LINES-1:0] ext_hwirq_i;
	logic [EXC_W-1:0] exc_code_i;
	logic in_bds_i, exit_isr_i, take_exc_o;
	logic [DATA_W-1:0] curr_pc_i, epc_o;

	row_t rows[$];
	logic [DATA_W-1:0] epc_exp = '0; // epc_o as it must read in the next table row
	logic [DATA_W-1:0] rdata;
	logic [DATA_W-1:0] rnd_epc;
	cp0_word_u rnd_status;
	cp0_word_u rnd_cause;
	integer seed = 32'h2d6b4068;
	int n;

	tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

	exc_subsys_top exc_subsys_top_inst (.rst_n_i(rst_n), .*);

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input cp0_word_u got, input cp0_word_u exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic cp0_word_u status_word(input logic [IRQ_LINES-1:0] im, input logic exl,
		input logic ie);
		cp0_word_u w;
		w = '0;
		w.status.im  = im;
		w.status.exl = exl;
		w.status.ie  = ie;
		return w;
	endfunction

	function automatic cp0_word_u cause_word(input logic bd, input logic [IRQ_LINES-1:0] ip,
		input logic [EXC_W-1:0] exc);
		cp0_word_u w;
		w = '0;
		w.cause.bd  = bd;
		w.cause.ip  = ip;
		w.cause.exc = exc;
		return w;
	endfunction

	task automatic add_row(input logic req, input logic dbg, input logic we,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
		input logic [IRQ_LINES-1:0] hwirq, input logic [EXC_W-1:0] exc, input logic bds,
		input logic [DATA_W-1:0] pc, input logic exit_isr, input logic chk_rd,
		input logic [DATA_W-1:0] exp_rd, input logic exp_take);
		row_t r;
		r = {req, dbg, we, addr, wdata, hwirq, exc, bds, pc, exit_isr, chk_rd, exp_rd, exp_take,
			epc_exp};
		rows.push_back(r);
		if (exp_take)
			epc_exp = bds ? pc - 32'd4 : pc; // delay slot points back at the branch
		else if (req && we && addr == ADDR_EPC)
			epc_exp = wdata;
	endtask

	task automatic run_row(input row_t r);
		@(posedge clk);
		#1;
		core_req_i   = r.req && !r.dbg;
		dbg_req_i    = r.req && r.dbg;
		core_we_i    = r.we;
		dbg_we_i     = r.we;
		core_addr_i  = r.addr;
		dbg_addr_i   = r.addr;
		core_wdata_i = r.wdata;
		dbg_wdata_i  = r.wdata;
		ext_hwirq_i  = r.hwirq;
		exc_code_i   = r.exc;
		in_bds_i     = r.bds;
		curr_pc_i    = r.pc;
		exit_isr_i   = r.exit_isr;
		@(negedge clk);
		check_bit("take_exc_o", take_exc_o, r.exp_take);
		check_word("epc_o", epc_o, r.exp_epc);
		if (r.req && r.dbg)
			check_bit("dbg_gnt_o", dbg_gnt_o, 1'b1);
		else if (r.req)
			check_bit("core_gnt_o", core_gnt_o, 1'b1);
		if (r.chk_rd && r.dbg)
			check_word("dbg_rdata_o", dbg_rdata_o, r.exp_rd);
		else if (r.chk_rd)
			check_word("core_rdata_o", core_rdata_o, r.exp_rd);
	endtask

	// one core access, request dropped after the edge that completes it
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rd);
		@(posedge clk);
		#1;
		core_req_i   = 1'b1;
		core_we_i    = we;
		core_addr_i  = addr;
		core_wdata_i = wdata;
		@(negedge clk);
		check_bit("core_gnt_o", core_gnt_o, 1'b1);
		rd = core_rdata_o;
		@(posedge clk);
		#1;
		core_req_i = 1'b0;
	endtask

	initial begin
		core_req_i   = 1'b0;
		core_we_i    = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		dbg_req_i    = 1'b0;
		dbg_we_i     = 1'b0;
		dbg_addr_i   = '0;
		dbg_wdata_i  = '0;
		ext_hwirq_i  = '0;
		exc_code_i   = EXC_NONE;
		in_bds_i     = 1'b0;
		curr_pc_i    = '0;
		exit_isr_i   = 1'b0;
		rnd_status   = $random(seed);
		rnd_cause    = $random(seed);
		rnd_epc      = $random(seed);

		n = 0;
		while (rst_n !== 1'b1) begin
			if (n == TIMEOUT_CYCLES) begin
				$display("reset was never released");
				abort_run();
			end
			@(posedge clk);
			n++;
		end
		@(negedge clk);
		check_bit("take_exc_o", take_exc_o, 1'b0);
		check_bit("core_gnt_o", core_gnt_o, 1'b0);
		check_bit("dbg_gnt_o", dbg_gnt_o, 1'b0);

		// req dbg we addr wdata hwirq exc bds pc exit chk_rd exp_rd take
		add_row(1, 0, 0, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 1, 0, 0);
		add_row(1, 0, 0, ADDR_CAUSE, 0, 0, EXC_NONE, 0, 0, 0, 1, 0, 0);
		add_row(1, 0, 0, ADDR_EPC, 0, 0, EXC_NONE, 0, 0, 0, 1, 0, 0);
		add_row(1, 1, 0, ADDR_PRID, 0, 0, EXC_NONE, 0, 0, 0, 1, CP0_PRID, 0);
		add_row(1, 0, 0, 5'd3, 0, 0, EXC_NONE, 0, 0, 0, 1, 0, 0); // unmapped
		add_row(1, 0, 1, ADDR_STATUS, rnd_status, 0, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 0, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 1,
			status_word(rnd_status.status.im, rnd_status.status.exl, rnd_status.status.ie), 0);
		add_row(1, 0, 1, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 1, ADDR_CAUSE, rnd_cause, HW_PAT, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 1, ADDR_EPC, rnd_epc, HW_PAT, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(1, 0, 0, ADDR_CAUSE, 0, HW_PAT, EXC_NONE, 0, 0, 0, 1,
			cause_word(rnd_cause.cause.bd, HW_PAT, rnd_cause.cause.exc), 0);
		add_row(1, 0, 0, ADDR_EPC, 0, 0, EXC_NONE, 0, 0, 0, 1, rnd_epc, 0);
		add_row(0, 0, 0, 0, 0, 0, 5'd4, 0, 32'h1000, 0, 0, 0, 1);
		add_row(1, 0, 0, ADDR_CAUSE, 0, 0, 5'd10, 1, 32'h1104, 0, 1, cause_word(0, 0, 5'd4), 0);
		add_row(1, 0, 0, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 1, status_word(0, 1, 0), 0);
		add_row(0, 0, 0, 0, 0, 0, EXC_NONE, 0, 0, 1, 0, 0, 0); // handler returns
		add_row(1, 0, 0, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 1, 0, 0);
		add_row(0, 0, 0, 0, 0, 0, 5'd12, 1, 32'h2004, 0, 0, 0, 1);
		add_row(1, 0, 0, ADDR_CAUSE, 0, 0, EXC_NONE, 0, 0, 0, 1, cause_word(1, 0, 5'd12), 0);
		add_row(0, 0, 0, 0, 0, 0, EXC_NONE, 0, 0, 1, 0, 0, 0);
		add_row(1, 0, 1, ADDR_STATUS, status_word(6'h04, 0, 0), 6'h04, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(0, 0, 0, 0, 0, 6'h04, EXC_NONE, 0, 0, 0, 0, 0, 0); // ie clear
		add_row(1, 0, 1, ADDR_STATUS, status_word(6'h08, 0, 1), 6'h04, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(0, 0, 0, 0, 0, 6'h04, EXC_NONE, 0, 0, 0, 0, 0, 0); // line 2 masked
		add_row(1, 0, 1, ADDR_STATUS, status_word(6'h04, 0, 1), 6'h04, EXC_NONE, 0, 0, 0, 0, 0, 0);
		add_row(0, 0, 0, 0, 0, 6'h04, EXC_NONE, 0, 32'h3000, 0, 0, 0, 1);
		add_row(1, 0, 0, ADDR_CAUSE, 0, 6'h04, EXC_NONE, 0, 0, 0, 1, cause_word(0, 6'h04, 0), 0);
		add_row(0, 0, 0, 0, 0, 0, EXC_NONE, 0, 0, 1, 0, 0, 0);
		add_row(1, 0, 1, ADDR_STATUS, 0, 0, EXC_NONE, 0, 0, 0, 0, 0, 0);
		foreach (rows[i]) begin
			run_row(rows[i]);
		end

		// both masters at once, debug keeps its write pending
		@(posedge clk);
		#1;
		core_req_i  = 1'b1;
		core_we_i   = 1'b0;
		core_addr_i = ADDR_STATUS;
		dbg_req_i   = 1'b1;
		dbg_we_i    = 1'b1;
		dbg_addr_i  = ADDR_EPC;
		dbg_wdata_i = DBG_EPC;
		@(negedge clk);
		check_bit("core_gnt_o", core_gnt_o, 1'b1);
		check_bit("dbg_gnt_o", dbg_gnt_o, 1'b0);
		@(posedge clk);
		#1;
		core_req_i = 1'b0;
		n = 0;
		@(negedge clk);
		while (dbg_gnt_o !== 1'b1) begin
			if (n == TIMEOUT_CYCLES) begin
				$display("debug port was not granted after the core released the bus");
				abort_run();
			end
			@(negedge clk);
			n++;
		end
		@(posedge clk);
		#1;
		dbg_req_i = 1'b0;
		bus_access(1'b0, ADDR_EPC, '0, rdata);
		check_word("core_rdata_o", rdata, DBG_EPC);

		// count runs up to compare, line 5 unmasked
		curr_pc_i = 32'h0000_4000;
		bus_access(1'b1, ADDR_COMPARE, TMR_CMP, rdata);
		bus_access(1'b1, ADDR_COUNT, TMR_CMP - 32'd4, rdata);
		bus_access(1'b1, ADDR_STATUS, status_word(6'h20, 1'b0, 1'b1), rdata);
		n = 0;
		@(negedge clk);
		while (take_exc_o !== 1'b1) begin
			if (n == TIMEOUT_CYCLES) begin
				$display("timer interrupt was never taken");
				abort_run();
			end
			@(negedge clk);
			n++;
		end
		bus_access(1'b0, ADDR_CAUSE, '0, rdata);
		check_word("core_rdata_o", rdata, cause_word(1'b0, 6'h20, EXC_INT));
		check_word("epc_o", epc_o, 32'h0000_4000);
		bus_access(1'b1, ADDR_COMPARE, '1, rdata); // acknowledges the timer
		bus_access(1'b0, ADDR_CAUSE, '0, rdata);
		check_word("core_rdata_o", rdata, cause_word(1'b0, 6'h00, EXC_INT));
		check_bit("take_exc_o", take_exc_o, 1'b0);

		$display("TEST PASS");
		$finish;
	end

endmodule
